// File: soc_ctrl.f
hdl/soc_ctrl_pkg.sv
hdl/bus_decode.sv
hdl/dev_table.sv
hdl/int_ctrl.sv
hdl/word_ram.sv
hdl/rst_seq.sv
hdl/read_return.sv
hdl/soc_ctrl_top.sv
tb/soc_ctrl_checker.sv
tb/soc_ctrl_tb.sv

// File: tb/soc_ctrl_tb.sv
`default_nettype none
`timescale 1ns/1ps

module soc_ctrl_tb;
	import soc_ctrl_pkg::*;

	typedef enum logic [1:0] {
		ACT_PLAIN,
		ACT_BOUNCE,
		ACT_POWEROFF
	} act_t;

	// one table entry, chk_irq picks irq_o over rd_data_o
	typedef struct packed {
		pi_op_t     op;
		word_addr_t addr;
		word_t      data;
		sel_t       sel;
		logic [2:0] irq;
		word_t      exp;
		logic       chk_irq;
		act_t       act;
	} step_t;

	logic       clk120mhz = 1'b0;
	logic       rst_p;
	bus_req_t   bus_req;
	logic       rdy;
	word_t      rd_data;
	logic [2:0] irq_src;
	logic       irq;

	step_t steps[$];
	word_t ram_model [64];
	word_t rng;
	int    ram_addr [5] = '{3, 17, 40, 63, 0};
	sel_t  part_sel [5] = '{4'b0101, 4'b1000, 4'b0011, 4'b1111, 4'b0110};

	soc_ctrl_top dut0 (
		.clk120mhz (clk120mhz),
		.rst_p     (rst_p),
		.bus_req_i (bus_req),
		.rdy_o     (rdy),
		.rd_data_o (rd_data),
		.irq_src_i (irq_src),
		.irq_o     (irq)
	);

	always #4 clk120mhz = ~clk120mhz;

	function automatic word_t xorshift(input word_t s);
		word_t x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// byte lanes with sel set take the new data
	function automatic word_t merge_bytes(input word_t old, input word_t nw, input sel_t sel);
		word_t r;
		r = old;
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				r[8*b +: 8] = nw[8*b +: 8];
		end
		return r;
	endfunction

	task automatic abort_run();
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic wait_rdy(input logic lvl, input int limit, input string what);
		int n;
		n = 0;
		while (rdy !== lvl) begin
			if (n >= limit) begin
				$display("timeout waiting for %s after %0d cycles", what, limit);
				abort_run();
			end else begin
				@(posedge clk120mhz);
				#1;
				n++;
			end
		end
	endtask

	task automatic pulse_reset();
		rst_p = 1'b1;
		repeat (2) @(posedge clk120mhz);
		#1;
		rst_p = 1'b0;
	endtask

	task automatic add_step(input pi_op_t op, input word_t addr, input word_t data,
		input sel_t sel, input logic [2:0] irq_v, input word_t exp, input logic chk_irq,
		input act_t act);
		step_t s;
		s.op      = op;
		s.addr    = word_addr_t'(addr);
		s.data    = data;
		s.sel     = sel;
		s.irq     = irq_v;
		s.exp     = exp;
		s.chk_irq = chk_irq;
		s.act     = act;
		steps.push_back(s);
	endtask

	task automatic build_steps();
		word_t dev_exp [8];
		word_t rst_word;
		dev_exp = '{ID_RAM, RAM_SIZE, ID_DEVTBL, DEVTBL_SIZE,
			ID_INTCTRL, INTCTRL_SIZE, ID_INVALID, INVALID_SIZE};
		rst_word = DEVTBL_BASE + DEVTBL_RST_WORD;
		// full writes, then partial overwrites, then read back
		for (int i = 0; i < 5; i++) begin
			rng = xorshift(rng);
			ram_model[ram_addr[i]] = rng;
			add_step(OP_WRITE, ram_addr[i], rng, 4'hf, 3'b0, 32'd0, 1'b1, ACT_PLAIN);
		end
		for (int i = 0; i < 5; i++) begin
			rng = xorshift(rng);
			ram_model[ram_addr[i]] = merge_bytes(ram_model[ram_addr[i]], rng, part_sel[i]);
			add_step(OP_WRITE, ram_addr[i], rng, part_sel[i], 3'b0, 32'd0, 1'b1, ACT_PLAIN);
		end
		for (int i = 0; i < 5; i++)
			add_step(OP_READ, ram_addr[i], 0, 0, 0, ram_model[ram_addr[i]], 1'b0, ACT_PLAIN);
		for (int i = 0; i < 8; i++)
			add_step(OP_READ, DEVTBL_BASE + i, 0, 0, 0, dev_exp[i], 1'b0, ACT_PLAIN);
		// invalid device reads zero and ignores writes
		add_step(OP_READ, 200, 0, 0, 0, 32'd0, 1'b0, ACT_PLAIN);
		add_step(OP_WRITE, 200, 32'hffff_ffff, 4'hf, 0, 32'd0, 1'b1, ACT_PLAIN);
		add_step(OP_READ, 40, 0, 0, 0, ram_model[40], 1'b0, ACT_PLAIN);
		add_step(OP_READ, 200, 0, 0, 0, 32'd0, 1'b0, ACT_PLAIN);
		// source 1 pulse, unmask, clear
		add_step(OP_NOOP, 0, 0, 0, 3'b010, 32'd0, 1'b1, ACT_PLAIN);
		add_step(OP_READ, INTCTRL_BASE, 0, 0, 0, 32'd2, 1'b0, ACT_PLAIN);
		add_step(OP_WRITE, INTCTRL_BASE + 1, 32'd2, 4'hf, 0, 32'd1, 1'b1, ACT_PLAIN);
		add_step(OP_READ, INTCTRL_BASE + 2, 0, 0, 0, 32'd1, 1'b0, ACT_PLAIN);
		add_step(OP_WRITE, INTCTRL_BASE, 32'd2, 4'hf, 0, 32'd0, 1'b1, ACT_PLAIN);
		add_step(OP_READ, INTCTRL_BASE, 0, 0, 0, 32'd0, 1'b0, ACT_PLAIN);
		// warm reset keeps ram but clears the mask
		add_step(OP_WRITE, rst_word, 32'd2, 4'hf, 0, 32'd0, 1'b1, ACT_BOUNCE);
		add_step(OP_READ, ram_addr[0], 0, 0, 0, ram_model[ram_addr[0]], 1'b0, ACT_PLAIN);
		add_step(OP_READ, INTCTRL_BASE + 1, 0, 0, 0, 32'd0, 1'b0, ACT_PLAIN);
		add_step(OP_WRITE, rst_word, 32'd1, 4'hf, 0, 32'd0, 1'b1, ACT_POWEROFF);
	endtask

	task automatic apply_step(input step_t s);
		wait_rdy(1'b1, 100, "rdy_o before a request");
		bus_req.op   = s.op;
		bus_req.addr = s.addr;
		bus_req.data = s.data;
		bus_req.sel  = s.sel;
		irq_src      = s.irq;
		@(posedge clk120mhz);
		#1;
		bus_req.op = OP_NOOP;
		irq_src    = '0;
		if (s.chk_irq)
			check_val("irq_o", word_t'(irq), s.exp);
		else
			check_val("rd_data_o", rd_data, s.exp);
		case (s.act)
			ACT_BOUNCE: begin
				wait_rdy(1'b0, 20, "rdy_o to fall after warm reset");
				wait_rdy(1'b1, 100, "rdy_o to rise after warm reset");
			end
			ACT_POWEROFF: begin
				wait_rdy(1'b0, 20, "rdy_o to fall after power-off");
				repeat (64) begin
					@(posedge clk120mhz);
					#1;
					check_val("rdy_o", word_t'(rdy), 32'd0);
				end
				pulse_reset();
				wait_rdy(1'b1, 20, "rdy_o to rise after rst_p");
				check_val("rd_data_o", rd_data, 32'd0);
				check_val("irq_o", word_t'(irq), 32'd0);
			end
			default: ;
		endcase
	endtask

	// second read is decoded while the first one returns
	task automatic read_back_to_back(input int a0, input int a1);
		wait_rdy(1'b1, 100, "rdy_o before back-to-back reads");
		bus_req.op   = OP_READ;
		bus_req.addr = word_addr_t'(a0);
		@(posedge clk120mhz);
		#1;
		bus_req.addr = word_addr_t'(a1);
		check_val("rd_data_o", rd_data, ram_model[a0]);
		@(posedge clk120mhz);
		#1;
		bus_req.op = OP_NOOP;
		check_val("rd_data_o", rd_data, ram_model[a1]);
	endtask

	initial begin
		rst_p   = 1'b1;
		bus_req = '0;
		irq_src = '0;
		rng     = 32'h31bab852;
		build_steps();
		pulse_reset();
		wait_rdy(1'b1, 20, "rdy_o to rise after reset");
		check_val("rd_data_o", rd_data, 32'd0);
		check_val("irq_o", word_t'(irq), 32'd0);
		foreach (steps[i])
			apply_step(steps[i]);
		read_back_to_back(ram_addr[1], ram_addr[2]);
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/soc_ctrl_checker.sv
`default_nettype none
`timescale 1ns/1ps

module soc_ctrl_checker (
	input wire                         clk120mhz,
	input wire                         rst_p,
	input wire soc_ctrl_pkg::bus_req_t bus_req_i,
	input wire                         rdy_o,
	input wire soc_ctrl_pkg::word_t    rd_data_o,
	input wire                         irq_o
);
	import soc_ctrl_pkg::*;

	logic rd_accept;

	assign rd_accept = (bus_req_i.op == OP_READ) && rdy_o;

	rdy_low_after_rst: assert property (@(posedge clk120mhz) rst_p |=> !rdy_o)
		else $error("rdy_o high in the cycle after rst_p");

	irq_low_after_rst: assert property (@(posedge clk120mhz) rst_p |=> !irq_o)
		else $error("irq_o high in the cycle after rst_p");

	// read data only moves after an accepted read
	rd_data_holds: assert property (@(posedge clk120mhz) disable iff (rst_p)
		!rd_accept |=> $stable(rd_data_o))
		else $error("rd_data_o changed without an accepted read");

endmodule

bind soc_ctrl_top soc_ctrl_checker u_checker (
	.clk120mhz (clk120mhz),
	.rst_p     (rst_p),
	.bus_req_i (bus_req_i),
	.rdy_o     (rdy_o),
	.rd_data_o (rd_data_o),
	.irq_o     (irq_o)
);

`default_nettype wire

// File: hdl/soc_ctrl_top.sv
`default_nettype none
`timescale 1ns/1ps

module soc_ctrl_top (
	input  wire                                   clk120mhz,
	input  wire                                   rst_p,
	input  soc_ctrl_pkg::bus_req_t                 bus_req_i,
	output logic                                   rdy_o,
	output soc_ctrl_pkg::word_t                    rd_data_o,
	input  wire [soc_ctrl_pkg::IRQ_SRC_COUNT-1:0] irq_src_i,
	output logic                                   irq_o
);
	import soc_ctrl_pkg::*;

	logic       sys_rst;
	slave_req_t ram_req;
	slave_req_t devtbl_req;
	slave_req_t intctrl_req;
	rd_tag_t    rd_tag;
	rst_cmd_t   rst_cmd;
	word_t      ram_data;
	word_t      devtbl_data;
	word_t      intctrl_data;

	bus_decode u_bus_decode (
		.sys_rst_i     (sys_rst),
		.bus_req_i     (bus_req_i),
		.ram_req_o     (ram_req),
		.devtbl_req_o  (devtbl_req),
		.intctrl_req_o (intctrl_req),
		.rd_tag_o      (rd_tag),
		.rdy_o         (rdy_o)
	);

	word_ram u_word_ram (
		.clk120mhz (clk120mhz),
		.req_i     (ram_req),
		.rd_data_o (ram_data)
	);

	dev_table u_dev_table (
		.clk120mhz (clk120mhz),
		.rst_p     (rst_p),
		.sys_rst_i (sys_rst),
		.req_i     (devtbl_req),
		.rd_data_o (devtbl_data),
		.rst_cmd_o (rst_cmd)
	);

	int_ctrl u_int_ctrl (
		.clk120mhz (clk120mhz),
		.rst_p     (rst_p),
		.sys_rst_i (sys_rst),
		.req_i     (intctrl_req),
		.irq_src_i (irq_src_i),
		.rd_data_o (intctrl_data),
		.irq_o     (irq_o)
	);

	rst_seq u_rst_seq (
		.clk120mhz (clk120mhz),
		.rst_p     (rst_p),
		.rst_cmd_i (rst_cmd),
		.sys_rst_o (sys_rst)
	);

	read_return u_read_return (
		.clk120mhz      (clk120mhz),
		.rst_p          (rst_p),
		.rd_tag_i       (rd_tag),
		.ram_data_i     (ram_data),
		.devtbl_data_i  (devtbl_data),
		.intctrl_data_i (intctrl_data),
		.rd_data_o      (rd_data_o)
	);

endmodule

`default_nettype wire

// File: hdl/read_return.sv
`default_nettype none
`timescale 1ns/1ps

module read_return (
	input  wire                  clk120mhz,
	input  wire                  rst_p,
	input  soc_ctrl_pkg::rd_tag_t rd_tag_i,
	input  soc_ctrl_pkg::word_t   ram_data_i,
	input  soc_ctrl_pkg::word_t   devtbl_data_i,
	input  soc_ctrl_pkg::word_t   intctrl_data_i,
	output soc_ctrl_pkg::word_t   rd_data_o
);
	import soc_ctrl_pkg::*;

	rd_tag_t tag_q;

	// tag only moves on an accepted read so the output holds in between
	always_ff @(posedge clk120mhz) begin
		if (rst_p)
			tag_q <= '0;
		else if (rd_tag_i.hit)
			tag_q <= rd_tag_i;
	end

	always_comb begin
		rd_data_o = '0;
		if (tag_q.hit) begin
			case (tag_q.slave)
				slave_idx_t'(S_RAM):     rd_data_o = ram_data_i;
				slave_idx_t'(S_DEVTBL):  rd_data_o = devtbl_data_i;
				slave_idx_t'(S_INTCTRL): rd_data_o = intctrl_data_i;
				default:                 rd_data_o = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/rst_seq.sv
`default_nettype none
`timescale 1ns/1ps

module rst_seq (
	input  wire                   clk120mhz,
	input  wire                   rst_p,
	input  soc_ctrl_pkg::rst_cmd_t rst_cmd_i,
	output logic                  sys_rst_o
);
	import soc_ctrl_pkg::*;

	logic [RST_CNTR_W-1:0] rst_cntr;
	logic                  pwr_off;

	// reload on any reset reason, then count down to release
	always_ff @(posedge clk120mhz) begin
		if (rst_p || rst_cmd_i.cold || rst_cmd_i.warm)
			rst_cntr <= '1;
		else if (rst_cntr != '0)
			rst_cntr <= rst_cntr - 1'b1;
	end

	// power-off is only left through a hard or cold reset
	always_ff @(posedge clk120mhz) begin
		if (rst_p || rst_cmd_i.cold)
			pwr_off <= 1'b0;
		else if (rst_cmd_i.poweroff)
			pwr_off <= 1'b1;
	end

	assign sys_rst_o = (rst_cntr != '0) || pwr_off;

endmodule

`default_nettype wire

// File: hdl/word_ram.sv
`default_nettype none
`timescale 1ns/1ps

module word_ram (
	input  wire                     clk120mhz,
	input  soc_ctrl_pkg::slave_req_t req_i,
	output soc_ctrl_pkg::word_t      rd_data_o
);
	import soc_ctrl_pkg::*;

	word_t mem [RAM_SIZE];

	// byte lanes written one by one
	always_ff @(posedge clk120mhz) begin
		if (req_i.op == OP_WRITE) begin
			for (int b = 0; b < 4; b++) begin
				if (req_i.sel[b])
					mem[req_i.offset][8*b +: 8] <= req_i.data[8*b +: 8];
			end
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (req_i.op == OP_READ)
			rd_data_o <= mem[req_i.offset];
	end

endmodule

`default_nettype wire

// File: hdl/int_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module int_ctrl (
	input  wire                                   clk120mhz,
	input  wire                                   rst_p,
	input  wire                                   sys_rst_i,
	input  soc_ctrl_pkg::slave_req_t               req_i,
	input  wire [soc_ctrl_pkg::IRQ_SRC_COUNT-1:0] irq_src_i,
	output soc_ctrl_pkg::word_t                    rd_data_o,
	output logic                                   irq_o
);
	import soc_ctrl_pkg::*;

	logic [IRQ_SRC_COUNT-1:0] pending;
	logic [IRQ_SRC_COUNT-1:0] mask;
	logic [IRQ_SRC_COUNT-1:0] active;
	logic [IRQ_SRC_COUNT-1:0] clr;
	logic                     wr_low;

	// lowest active index, all ones when nothing is active
	function automatic word_t lowest(input logic [IRQ_SRC_COUNT-1:0] act);
		word_t idx;
		idx = '1;
		for (int i = int'(IRQ_SRC_COUNT) - 1; i >= 0; i--) begin
			if (act[i])
				idx = word_t'(i);
		end
		return idx;
	endfunction

	assign wr_low = (req_i.op == OP_WRITE) && req_i.sel[0];
	assign clr    = (wr_low && req_i.offset == INT_PEND_WORD) ?
		req_i.data[IRQ_SRC_COUNT-1:0] : '0;
	assign active = pending & mask;
	assign irq_o  = |active;

	// a source still high wins over the clear
	always_ff @(posedge clk120mhz) begin
		if (rst_p || sys_rst_i) begin
			pending <= '0;
			mask    <= '0;
		end else begin
			pending <= (pending & ~clr) | irq_src_i;
			if (wr_low && req_i.offset == INT_MASK_WORD)
				mask <= req_i.data[IRQ_SRC_COUNT-1:0];
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (req_i.op == OP_READ) begin
			case (req_i.offset)
				INT_PEND_WORD: rd_data_o <= word_t'(pending);
				INT_MASK_WORD: rd_data_o <= word_t'(mask);
				INT_LOW_WORD:  rd_data_o <= lowest(active);
				default:       rd_data_o <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/dev_table.sv
`default_nettype none
`timescale 1ns/1ps

module dev_table (
	input  wire                     clk120mhz,
	input  wire                     rst_p,
	input  wire                     sys_rst_i,
	input  soc_ctrl_pkg::slave_req_t req_i,
	output soc_ctrl_pkg::word_t      rd_data_o,
	output soc_ctrl_pkg::rst_cmd_t   rst_cmd_o
);
	import soc_ctrl_pkg::*;

	logic rst_wr;

	// two words per slave: identifier then map size
	function automatic word_t table_word(input offset_t off);
		word_t id;
		word_t sz;
		case (off[2:1])
			slave_idx_t'(S_RAM): begin
				id = ID_RAM;
				sz = RAM_SIZE;
			end
			slave_idx_t'(S_DEVTBL): begin
				id = ID_DEVTBL;
				sz = DEVTBL_SIZE;
			end
			slave_idx_t'(S_INTCTRL): begin
				id = ID_INTCTRL;
				sz = INTCTRL_SIZE;
			end
			default: begin
				id = ID_INVALID;
				sz = INVALID_SIZE;
			end
		endcase
		if (word_t'(off) >= 2 * SLAVE_COUNT)
			return '0;
		return off[0] ? sz : id;
	endfunction

	assign rst_wr = (req_i.op == OP_WRITE) && req_i.sel[0] &&
		(req_i.offset == offset_t'(DEVTBL_RST_WORD));

	always_ff @(posedge clk120mhz) begin
		if (req_i.op == OP_READ)
			rd_data_o <= table_word(req_i.offset);
	end

	// command pulses last a single cycle
	always_ff @(posedge clk120mhz) begin
		if (rst_p || sys_rst_i) begin
			rst_cmd_o <= '0;
		end else begin
			rst_cmd_o.cold     <= rst_wr && (req_i.data[1:0] == 2'd3);
			rst_cmd_o.warm     <= rst_wr && (req_i.data[1:0] == 2'd2);
			rst_cmd_o.poweroff <= rst_wr && (req_i.data[1:0] == 2'd1);
		end
	end

endmodule

`default_nettype wire

// File: hdl/bus_decode.sv
`default_nettype none
`timescale 1ns/1ps

module bus_decode (
	input  wire                     sys_rst_i,
	input  soc_ctrl_pkg::bus_req_t   bus_req_i,
	output soc_ctrl_pkg::slave_req_t ram_req_o,
	output soc_ctrl_pkg::slave_req_t devtbl_req_o,
	output soc_ctrl_pkg::slave_req_t intctrl_req_o,
	output soc_ctrl_pkg::rd_tag_t    rd_tag_o,
	output logic                     rdy_o
);
	import soc_ctrl_pkg::*;

	slave_idx_t dec_slave;
	word_t      dec_base;
	logic       accept;

	function automatic logic in_map(input word_addr_t a, input word_t base, input word_t size);
		return (word_t'(a) >= base) && (word_t'(a) < base + size);
	endfunction

	// request as seen by one slave, op cleared unless it is the target
	function automatic slave_req_t route(input logic hit, input bus_req_t req,
		input word_t base);
		slave_req_t r;
		r.op     = hit ? req.op : OP_NOOP;
		r.offset = offset_t'(word_t'(req.addr) - base);
		r.data   = req.data;
		r.sel    = req.sel;
		return r;
	endfunction

	// anything past the mapped slaves falls to the invalid device
	always_comb begin
		dec_slave = slave_idx_t'(S_INVALID);
		dec_base  = INTCTRL_BASE + INTCTRL_SIZE;
		if (in_map(bus_req_i.addr, RAM_BASE, RAM_SIZE)) begin
			dec_slave = slave_idx_t'(S_RAM);
			dec_base  = RAM_BASE;
		end else if (in_map(bus_req_i.addr, DEVTBL_BASE, DEVTBL_SIZE)) begin
			dec_slave = slave_idx_t'(S_DEVTBL);
			dec_base  = DEVTBL_BASE;
		end else if (in_map(bus_req_i.addr, INTCTRL_BASE, INTCTRL_SIZE)) begin
			dec_slave = slave_idx_t'(S_INTCTRL);
			dec_base  = INTCTRL_BASE;
		end
	end

	assign rdy_o  = !sys_rst_i;
	assign accept = (bus_req_i.op != OP_NOOP) && rdy_o;

	assign ram_req_o     = route(accept && dec_slave == slave_idx_t'(S_RAM),
		bus_req_i, dec_base);
	assign devtbl_req_o  = route(accept && dec_slave == slave_idx_t'(S_DEVTBL),
		bus_req_i, dec_base);
	assign intctrl_req_o = route(accept && dec_slave == slave_idx_t'(S_INTCTRL),
		bus_req_i, dec_base);

	assign rd_tag_o.hit   = accept && (bus_req_i.op == OP_READ);
	assign rd_tag_o.slave = dec_slave;

endmodule

`default_nettype wire

// File: hdl/soc_ctrl_pkg.sv
`default_nettype none

package soc_ctrl_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0]  sel_t;
	typedef logic [15:0] word_addr_t;
	typedef logic [5:0]  offset_t;
	typedef logic [1:0]  slave_idx_t;

	// bus operation codes as the master drives them
	typedef enum logic [1:0] {
		OP_NOOP  = 2'd0,
		OP_WRITE = 2'd1,
		OP_READ  = 2'd2
	} pi_op_t;

	typedef struct packed {
		pi_op_t     op;
		word_addr_t addr;
		word_t      data;
		sel_t       sel;
	} bus_req_t;

	typedef struct packed {
		pi_op_t  op;
		offset_t offset;
		word_t   data;
		sel_t    sel;
	} slave_req_t;

	typedef struct packed {
		logic       hit;
		slave_idx_t slave;
	} rd_tag_t;

	typedef struct packed {
		logic cold;
		logic warm;
		logic poweroff;
	} rst_cmd_t;

	localparam word_t S_RAM       = 32'd0;
	localparam word_t S_DEVTBL    = 32'd1;
	localparam word_t S_INTCTRL   = 32'd2;
	localparam word_t S_INVALID   = 32'd3;
	localparam word_t SLAVE_COUNT = 32'd4;

	// address map in words
	localparam word_t RAM_BASE     = 32'd0;
	localparam word_t RAM_SIZE     = 32'd64;
	localparam word_t DEVTBL_BASE  = 32'd64;
	localparam word_t DEVTBL_SIZE  = 32'd16;
	localparam word_t INTCTRL_BASE = 32'd80;
	localparam word_t INTCTRL_SIZE = 32'd16;
	localparam word_t INVALID_SIZE = 32'd16;

	localparam word_t ID_RAM     = 32'd1;
	localparam word_t ID_DEVTBL  = 32'd7;
	localparam word_t ID_INTCTRL = 32'd3;
	localparam word_t ID_INVALID = 32'd0;

	localparam word_t DEVTBL_RST_WORD = 32'd8;
	// sources are sd card, dma and uart in that order
	localparam word_t IRQ_SRC_COUNT   = 32'd3;
	localparam word_t RST_CNTR_W      = 32'd4;

	// interrupt controller register words
	localparam offset_t INT_PEND_WORD = 6'd0;
	localparam offset_t INT_MASK_WORD = 6'd1;
	localparam offset_t INT_LOW_WORD  = 6'd2;

endpackage

`default_nettype wire
